/* logic/uart_pkg.sv */
// shared constants and types for the 8N1 UART subsystem
// fifo_depth must stay a power of two because the FIFO pointers wrap freely
`default_nettype none

package uart_pkg;

   // bit timing
   localparam int div_w = 16;
   localparam logic [div_w-1:0] div_reset = 16'd16;
   localparam logic [div_w-1:0] div_min = 16'd2;

   // FIFO geometry
   localparam int fifo_depth = 4;
   localparam int fifo_cnt_w = 3;
   localparam int fifo_ptr_w = 2;

   // register map of the host bus
   localparam int addr_w = 2;
   localparam logic [addr_w-1:0] addr_div = 2'd0;
   localparam logic [addr_w-1:0] addr_txdata = 2'd1;
   localparam logic [addr_w-1:0] addr_rxdata = 2'd2;
   localparam logic [addr_w-1:0] addr_status = 2'd3;

   // status register bit positions
   localparam int st_tx_full = 0;
   localparam int st_tx_busy = 1;
   localparam int st_rx_valid = 2;
   localparam int st_overrun = 3;
   localparam int st_frame_seen = 4;

   // one received character as it sits in the receive FIFO
   typedef struct packed {
      logic [7:0] data;
      logic       frame_err;
   } rx_entry_t;

endpackage

`default_nettype wire

/* logic/uart_fifo.sv */
// small synchronous FIFO holding fifo_depth entries of payload_t
// dout shows the head entry whenever not_empty is high
// a push into a full FIFO is discarded and flagged on dropped a cycle later
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     push,
   input  payload_t din,
   input  logic     pop,
   output payload_t dout,
   output logic     not_empty,
   output logic     full,
   output logic     dropped
);

   import uart_pkg::*;

   payload_t                mem [fifo_depth];
   logic [fifo_ptr_w-1:0]   wr_ptr;
   logic [fifo_ptr_w-1:0]   rd_ptr;
   logic [fifo_cnt_w-1:0]   cnt;
   logic                    do_push;
   logic                    do_pop;

   assign full      = (cnt == fifo_cnt_w'(fifo_depth));
   assign not_empty = (cnt != '0);
   assign dout      = mem[rd_ptr];

   // a full FIFO refuses the push even if a pop happens in the same cycle
   assign do_push = push && !full;
   assign do_pop  = pop && not_empty;

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         cnt     <= '0;
         dropped <= 1'b0;
      end else begin
         dropped <= push && full;
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   cnt <= cnt + 1'b1;
            2'b01:   cnt <= cnt - 1'b1;
            default: cnt <= cnt;
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
// 8N1 serializer, LSB first, each bit held for div cycles
// take is a one-cycle pop of the byte offered on data/avail
// div is expected to stay constant while a frame is on the line
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [uart_pkg::div_w-1:0] div,
   input  logic [7:0]                data,
   input  logic                      avail,
   output logic                      take,
   output logic                      busy,
   output logic                      tx
);

   import uart_pkg::*;

   logic             active;
   logic [9:0]       frame;
   logic [3:0]       bit_cnt;
   logic [div_w-1:0] cyc_cnt;
   logic             bit_end;

   // a new byte is taken only between frames
   assign take = avail && !active;

   // busy covers the take cycle and the whole frame including the stop bit
   assign busy = active || avail;

   assign bit_end = (cyc_cnt == div - div_w'(1));

   // the line is driven straight from the frame register, ones fill in behind
   assign tx = frame[0];

   // --------------------------------------------------------------------------
   // frame shifter
   // --------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         active  <= 1'b0;
         frame   <= '1;
         bit_cnt <= '0;
         cyc_cnt <= '0;
      end else if (take) begin
         // stop bit, data, start bit, so the start bit goes out first
         frame   <= {1'b1, data, 1'b0};
         active  <= 1'b1;
         bit_cnt <= '0;
         cyc_cnt <= '0;
      end else if (active) begin
         if (bit_end) begin
            cyc_cnt <= '0;
            frame   <= {1'b1, frame[9:1]};
            if (bit_cnt == 4'd9) begin
               active <= 1'b0;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
// 8N1 deserializer with a two-flop input synchronizer
// the start bit is rechecked at div/2, later bits are sampled every div cycles
// no oversampling filter, a glitch at a sample point is taken as data
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [uart_pkg::div_w-1:0] div,
   input  logic                       rx,
   output logic                       push,
   output uart_pkg::rx_entry_t        entry
);

   import uart_pkg::*;

   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_t;

   rx_state_t        state;
   logic             rx_meta;
   logic             rx_s;
   logic [div_w-1:0] cyc_cnt;
   logic [2:0]       bit_cnt;
   logic [7:0]       shreg;
   logic             half_end;
   logic             bit_end;

   assign half_end = (cyc_cnt == (div >> 1) - div_w'(1));
   assign bit_end  = (cyc_cnt == div - div_w'(1));

   // synchronizer resets to the idle line level so reset gives no false start
   always_ff @(posedge clk) begin
      if (rst) begin
         rx_meta <= 1'b1;
         rx_s    <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_s    <= rx_meta;
      end
   end

   // --------------------------------------------------------------------------
   // frame state machine
   // --------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      push <= 1'b0;
      if (rst) begin
         state   <= rx_idle;
         cyc_cnt <= '0;
         bit_cnt <= '0;
         push    <= 1'b0;
      end else begin
         case (state)
            rx_idle: begin
               cyc_cnt <= '0;
               bit_cnt <= '0;
               if (!rx_s) begin
                  state <= rx_start;
               end
            end
            rx_start: begin
               if (half_end) begin
                  cyc_cnt <= '0;
                  // line back high at mid start bit means it was only a glitch
                  state <= rx_s ? rx_idle : rx_data;
               end else begin
                  cyc_cnt <= cyc_cnt + 1'b1;
               end
            end
            rx_data: begin
               if (bit_end) begin
                  cyc_cnt <= '0;
                  if (bit_cnt == 3'd7) begin
                     state <= rx_stop;
                  end
                  bit_cnt <= bit_cnt + 1'b1;
               end else begin
                  cyc_cnt <= cyc_cnt + 1'b1;
               end
            end
            rx_stop: begin
               if (bit_end) begin
                  push  <= 1'b1;
                  state <= rx_idle;
               end else begin
                  cyc_cnt <= cyc_cnt + 1'b1;
               end
            end
            default: state <= rx_idle;
         endcase
      end
   end

   // data path, LSB arrives first so bits enter from the top
   always_ff @(posedge clk) begin
      if (state == rx_data && bit_end) begin
         shreg <= {rx_s, shreg[7:1]};
      end
      if (state == rx_stop && bit_end) begin
         entry.data      <= shreg;
         entry.frame_err <= !rx_s;
      end
   end

endmodule

`default_nettype wire

/* logic/uart_regs.sv */
// four-phase req/ack register block in front of the UART
// only a txdata write into a full transmit FIFO holds ack back
// divisor writes below div_min are raised to div_min
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        req,
   input  logic                        we,
   input  logic [uart_pkg::addr_w-1:0] addr,
   input  logic [15:0]                 wdata,
   output logic                        ack,
   output logic [15:0]                 rdata,
   output logic [uart_pkg::div_w-1:0]  div,
   output logic                        tx_push,
   output logic [7:0]                  tx_byte,
   input  logic                        tx_full,
   input  logic                        tx_busy,
   output logic                        rx_pop,
   input  uart_pkg::rx_entry_t         rx_head,
   input  logic                        rx_valid,
   input  logic                        rx_dropped
);

   import uart_pkg::*;

   typedef enum logic [1:0] {
      hs_idle,
      hs_stall,
      hs_ack
   } hs_state_t;

   hs_state_t   state;
   logic        tx_write;
   logic        stall_req;
   logic        xfer;
   logic        do_wr_div;
   logic        do_push;
   logic        do_rd;
   logic        overrun;
   logic        frame_seen;
   logic [15:0] rd_word;

   // --------------------------------------------------------------------------
   // transfer decode
   // --------------------------------------------------------------------------

   assign tx_write  = we && (addr == addr_txdata);
   assign stall_req = (state == hs_idle) && req && tx_write && tx_full;

   // xfer marks the one cycle in which a transfer takes effect
   assign xfer = ((state == hs_idle) && req && !(tx_write && tx_full))
              || ((state == hs_stall) && !tx_full);

   assign do_wr_div = xfer && we && (addr == addr_div);
   assign do_push   = xfer && tx_write;
   assign do_rd     = xfer && !we;

   always_comb begin
      rd_word = '0;
      case (addr)
         addr_div: rd_word = div;
         addr_rxdata: begin
            if (rx_valid) begin
               rd_word = {6'b0, 1'b1, rx_head.frame_err, rx_head.data};
            end
         end
         addr_status: begin
            rd_word[st_tx_full]    = tx_full;
            rd_word[st_tx_busy]    = tx_busy;
            rd_word[st_rx_valid]   = rx_valid;
            rd_word[st_overrun]    = overrun;
            rd_word[st_frame_seen] = frame_seen;
         end
         default: rd_word = '0;
      endcase
   end

   // --------------------------------------------------------------------------
   // handshake and registers
   // --------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= hs_idle;
         ack        <= 1'b0;
         rdata      <= '0;
         div        <= div_reset;
         tx_push    <= 1'b0;
         rx_pop     <= 1'b0;
         overrun    <= 1'b0;
         frame_seen <= 1'b0;
      end else begin
         tx_push <= do_push;
         rx_pop  <= do_rd && (addr == addr_rxdata) && rx_valid;

         if (stall_req) begin
            state <= hs_stall;
         end else if (xfer) begin
            state <= hs_ack;
            ack   <= 1'b1;
         end else if (state == hs_ack && !req) begin
            state <= hs_idle;
            ack   <= 1'b0;
         end

         if (do_wr_div) begin
            div <= (wdata < div_min) ? div_min : wdata;
         end
         if (do_rd) begin
            rdata <= rd_word;
         end

         // a status read clears the sticky flags, a new drop in that cycle still sets
         if (do_rd && addr == addr_status) begin
            overrun    <= 1'b0;
            frame_seen <= 1'b0;
         end
         if (do_rd && addr == addr_rxdata && rx_valid && rx_head.frame_err) begin
            frame_seen <= 1'b1;
         end
         if (rx_dropped) begin
            overrun <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         tx_byte <= wdata[7:0];
      end
   end

endmodule

`default_nettype wire

/* logic/uart_top.sv */
// UART subsystem top with the host register block and the 8N1 serial pins
// tx idles high and rx must be held high when idle
`timescale 1ns/1ps
`default_nettype none

module uart_top (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        req,
   input  logic                        we,
   input  logic [uart_pkg::addr_w-1:0] addr,
   input  logic [15:0]                 wdata,
   output logic                        ack,
   output logic [15:0]                 rdata,
   output logic                        tx,
   input  logic                        rx
);

   import uart_pkg::*;

   logic [div_w-1:0] div;
   logic             tx_push;
   logic [7:0]       tx_byte;
   logic [7:0]       tx_data;
   logic             tx_avail;
   logic             tx_take;
   logic             tx_full;
   logic             tx_busy;
   logic             rx_push;
   rx_entry_t        rx_entry;
   rx_entry_t        rx_head;
   logic             rx_valid;
   logic             rx_pop;
   logic             rx_dropped;

   uart_regs i_uart_regs (
      .clk        (clk),
      .rst        (rst),
      .req        (req),
      .we         (we),
      .addr       (addr),
      .wdata      (wdata),
      .ack        (ack),
      .rdata      (rdata),
      .div        (div),
      .tx_push    (tx_push),
      .tx_byte    (tx_byte),
      .tx_full    (tx_full),
      .tx_busy    (tx_busy),
      .rx_pop     (rx_pop),
      .rx_head    (rx_head),
      .rx_valid   (rx_valid),
      .rx_dropped (rx_dropped)
   );

   // transmit FIFO between the register block and the serializer
   uart_fifo #(
      .payload_t (logic [7:0])
   ) i_tx_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (tx_push),
      .din       (tx_byte),
      .pop       (tx_take),
      .dout      (tx_data),
      .not_empty (tx_avail),
      .full      (tx_full),
      .dropped   ()
   );

   uart_tx i_uart_tx (
      .clk   (clk),
      .rst   (rst),
      .div   (div),
      .data  (tx_data),
      .avail (tx_avail),
      .take  (tx_take),
      .busy  (tx_busy),
      .tx    (tx)
   );

   uart_rx i_uart_rx (
      .clk   (clk),
      .rst   (rst),
      .div   (div),
      .rx    (rx),
      .push  (rx_push),
      .entry (rx_entry)
   );

   // receive FIFO reports overflow on dropped and applies no back-pressure
   uart_fifo #(
      .payload_t (rx_entry_t)
   ) i_rx_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (rx_push),
      .din       (rx_entry),
      .pop       (rx_pop),
      .dout      (rx_head),
      .not_empty (rx_valid),
      .full      (),
      .dropped   (rx_dropped)
   );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
// clock and reset source for the testbench, 40 ns period
// rst is held high for 16 rising edges and released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

/* test/uart_props.sv */
// bus handshake and tx framing properties, bound into uart_top
// the start bit length can only be told apart from data when the LSB is high
`timescale 1ns/1ps
`default_nettype none

module uart_props (
   input logic                       clk,
   input logic                       rst,
   input logic                       req,
   input logic                       ack,
   input logic [15:0]                rdata,
   input logic                       tx,
   input logic                       tx_busy,
   input logic                       tx_take,
   input logic [7:0]                 tx_data,
   input logic [uart_pkg::div_w-1:0] div
);

   import uart_pkg::*;

   logic             start_on;
   logic [div_w-1:0] start_cnt;
   logic             start_lsb;

   // start_on covers the div cycles after a take in which the start bit is on the line
   always_ff @(posedge clk) begin
      if (rst) begin
         start_on  <= 1'b0;
         start_cnt <= '0;
         start_lsb <= 1'b1;
      end else if (tx_take) begin
         start_on  <= 1'b1;
         start_cnt <= '0;
         start_lsb <= tx_data[0];
      end else if (start_on) begin
         if (start_cnt == div - div_w'(1)) begin
            start_on <= 1'b0;
         end
         start_cnt <= start_cnt + 1'b1;
      end
   end

   ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
      else $error("ack rose without a pending req");

   ack_fall: assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
      else $error("ack fell while req was still high");

   rdata_hold: assert property (@(posedge clk) disable iff (rst)
      ack && $past(ack) |-> $stable(rdata))
      else $error("rdata changed while ack was high");

   tx_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx)
      else $error("tx low while the transmitter is idle");

   start_low: assert property (@(posedge clk) disable iff (rst) start_on |-> !tx)
      else $error("start bit ended early");

   start_len: assert property (@(posedge clk) disable iff (rst)
      $fell(start_on) |-> (tx == start_lsb))
      else $error("start bit did not end after div cycles");

endmodule

bind uart_top uart_props i_uart_props (
   .clk     (clk),
   .rst     (rst),
   .req     (req),
   .ack     (ack),
   .rdata   (rdata),
   .tx      (tx),
   .tx_busy (tx_busy),
   .tx_take (tx_take),
   .tx_data (tx_data),
   .div     (div)
);

`default_nettype wire

/* test/uart_tb.sv */
// testbench for uart_top that drives the host bus and the rx pin on falling edges
// rx follows tx in loopback or comes from a bit-level injector timed by cur_div
// the first failed check stops the run
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

   import uart_pkg::*;

   localparam int ack_timeout = 2000;
   localparam int poll_limit  = 600;

   logic              clk;
   logic              rst;
   logic              req;
   logic              we;
   logic [addr_w-1:0] addr;
   logic [15:0]       wdata;
   logic              ack;
   logic [15:0]       rdata;
   logic              tx;
   logic              rx;
   logic              loop_sel;
   logic              inj_line;
   logic [31:0]       lfsr;
   logic [15:0]       exp_q[$];
   int                cur_div;

   tb_clock i_tb_clock (
      .clk (clk),
      .rst (rst)
   );

   uart_top i_uart_top (
      .clk   (clk),
      .rst   (rst),
      .req   (req),
      .we    (we),
      .addr  (addr),
      .wdata (wdata),
      .ack   (ack),
      .rdata (rdata),
      .tx    (tx),
      .rx    (rx)
   );

   assign rx = loop_sel ? tx : inj_line;

   // --------------------------------------------------------------------------
   // reference rules and random bytes
   // --------------------------------------------------------------------------

   // taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // rxdata word with bit 9 present, bit 8 frame error and the data in the low byte
   function automatic logic [15:0] rx_word(input logic [7:0] d, input logic ferr);
      logic [15:0] w;
      w      = '0;
      w[9]   = 1'b1;
      w[8]   = ferr;
      w[7:0] = d;
      return w;
   endfunction

   function automatic logic [15:0] status_word(input logic full, input logic busy,
                                               input logic valid, input logic ovr,
                                               input logic fseen);
      logic [15:0] w;
      w = '0;
      w[st_tx_full]    = full;
      w[st_tx_busy]    = busy;
      w[st_rx_valid]   = valid;
      w[st_overrun]    = ovr;
      w[st_frame_seen] = fseen;
      return w;
   endfunction

   task automatic next_byte(output logic [7:0] b);
      b = '0;
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_next(lfsr);
         b = {b[6:0], lfsr[0]};
      end
   endtask

   // --------------------------------------------------------------------------
   // failure reporting and checks
   // --------------------------------------------------------------------------

   task automatic give_up(input string why);
      $display("%s", why);
      $display("Test failures found");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
      assert (act === exp) else begin
         $display("ERROR: %s expected 16'h%04h actual 16'h%04h", name, exp, act);
         give_up("a read value did not match");
      end
   endtask

   // --------------------------------------------------------------------------
   // host bus, four-phase req/ack
   // --------------------------------------------------------------------------

   task automatic bus_cycle(input logic write, input logic [addr_w-1:0] a,
                            input logic [15:0] d, output logic [15:0] rd,
                            output int waited);
      int n;
      @(negedge clk);
      req   = 1'b1;
      we    = write;
      addr  = a;
      wdata = d;
      n = 0;
      @(negedge clk);
      while (!ack) begin
         if (n == ack_timeout) give_up($sformatf("no ack for a transfer to address %0d", a));
         n++;
         @(negedge clk);
      end
      rd = rdata;
      waited = n;
      req = 1'b0;
      we  = 1'b0;
      n = 0;
      @(negedge clk);
      while (ack) begin
         if (n == ack_timeout) give_up("ack stayed high after req fell");
         n++;
         @(negedge clk);
      end
   endtask

   task automatic bus_write(input logic [addr_w-1:0] a, input logic [15:0] d,
                            output int waited);
      logic [15:0] unused;
      bus_cycle(1'b1, a, d, unused, waited);
   endtask

   task automatic bus_read(input logic [addr_w-1:0] a, output logic [15:0] d);
      int waited;
      bus_cycle(1'b0, a, 16'h0000, d, waited);
   endtask

   task automatic read_check(input string name, input logic [addr_w-1:0] a,
                             input logic [15:0] exp);
      logic [15:0] w;
      bus_read(a, w);
      check_value(name, exp, w);
   endtask

   task automatic check_rx(input string name);
      logic [15:0] w;
      logic [15:0] exp;
      bus_read(addr_rxdata, w);
      if (exp_q.size() == 0) give_up("a byte was read but none was expected");
      exp = exp_q.pop_front();
      check_value(name, exp, w);
   endtask

   // --------------------------------------------------------------------------
   // waits and the serial injector
   // --------------------------------------------------------------------------

   task automatic wait_reset_done();
      int n;
      n = 0;
      @(posedge clk);
      while (rst) begin
         if (n == 64) give_up("reset was never released");
         n++;
         @(posedge clk);
      end
      @(negedge clk);
   endtask

   task automatic wait_rx_valid(input string name);
      logic [15:0] st;
      int          polls;
      polls = 0;
      bus_read(addr_status, st);
      while (!st[st_rx_valid]) begin
         if (polls == poll_limit) give_up($sformatf("no byte received in %s", name));
         polls++;
         bus_read(addr_status, st);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // start bit and data LSB first, then the chosen stop level and one idle bit time
   task automatic inject_frame(input logic [7:0] d, input logic stop_bit);
      logic [9:0] bits;
      bits = {stop_bit, d, 1'b0};
      @(negedge clk);
      for (int i = 0; i < 10; i++) begin
         inj_line = bits[i];
         idle_cycles(cur_div);
      end
      inj_line = 1'b1;
      idle_cycles(cur_div);
   endtask

   // --------------------------------------------------------------------------
   // test sequence
   // --------------------------------------------------------------------------

   initial begin : main
      logic [15:0] w;
      logic [7:0]  b;
      int          waited;
      req      = 1'b0;
      we       = 1'b0;
      addr     = '0;
      wdata    = '0;
      loop_sel = 1'b0;
      inj_line = 1'b1;
      lfsr     = 32'h10f3_9e03;
      cur_div  = 16;
      wait_reset_done();

      // reset values
      check_value("reset tx", 16'd1, {15'd0, tx});
      read_check("reset status", addr_status, 16'h0000);
      read_check("reset divisor", addr_div, 16'd16);
      bus_read(addr_rxdata, w);
      check_value("reset rxdata present", 16'd0, {15'd0, w[9]});

      // divisor floor and then the working divisor
      bus_write(addr_div, 16'd1, waited);
      read_check("divisor floor", addr_div, 16'd2);
      bus_write(addr_div, 16'd8, waited);
      cur_div = 8;
      read_check("divisor write", addr_div, 16'd8);

      // loopback of random bytes
      loop_sel = 1'b1;
      for (int i = 0; i < 8; i++) begin
         next_byte(b);
         exp_q.push_back(rx_word(b, 1'b0));
         bus_write(addr_txdata, {8'h00, b}, waited);
         wait_rx_valid("loopback");
         check_rx("loopback");
      end

      // six writes back to back where the last one has to wait for FIFO space
      for (int i = 0; i < 6; i++) begin
         next_byte(b);
         exp_q.push_back(rx_word(b, 1'b0));
         bus_write(addr_txdata, {8'h00, b}, waited);
         if (i == 5) begin
            assert (waited > cur_div) else
               give_up("sixth txdata write was acked while the transmit FIFO was full");
         end
      end
      bus_read(addr_status, w);
      check_value("backpressure tx_busy", 16'd1, {15'd0, w[st_tx_busy]});
      for (int i = 0; i < 6; i++) begin
         wait_rx_valid("backpressure");
         check_rx("backpressure");
      end

      // frame with a low stop bit
      loop_sel = 1'b0;
      next_byte(b);
      exp_q.push_back(rx_word(b, 1'b1));
      inject_frame(b, 1'b0);
      wait_rx_valid("frame error");
      check_rx("frame error");
      read_check("frame error status", addr_status, status_word(0, 0, 0, 0, 1));
      read_check("frame error cleared", addr_status, 16'h0000);

      // low pulse shorter than half a bit
      @(negedge clk);
      inj_line = 1'b0;
      idle_cycles(cur_div / 2 - 2);
      inj_line = 1'b1;
      idle_cycles(12 * cur_div);
      read_check("false start status", addr_status, 16'h0000);
      bus_read(addr_rxdata, w);
      check_value("false start rxdata present", 16'd0, {15'd0, w[9]});

      // six frames into a four entry FIFO
      for (int i = 0; i < 6; i++) begin
         next_byte(b);
         if (i < fifo_depth) begin
            exp_q.push_back(rx_word(b, 1'b0));
         end
         inject_frame(b, 1'b1);
      end
      read_check("overrun status", addr_status, status_word(0, 0, 1, 1, 0));
      for (int i = 0; i < fifo_depth; i++) begin
         check_rx("overrun");
      end
      bus_read(addr_rxdata, w);
      check_value("overrun rxdata present", 16'd0, {15'd0, w[9]});
      if (exp_q.size() != 0) give_up("some expected bytes were never read back");

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_top.sv
test/tb_clock.sv
test/uart_props.sv
test/uart_tb.sv

/* Makefile */
# Verilator build and run of the UART testbench
# a failing run ends in $fatal, which gives a non-zero exit status

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module uart_tb \
		--Mdir build -f flist.f
	./build/Vuart_tb

clean:
	rm -rf build
